// File: common/beat_if.sv
`timescale 1ns/10ps
`default_nettype none

// one pixel beat between read side, scaler and average
interface beat_if import isp_pkg::*; ();

    logic              beat_valid;
    logic [beat_w-1:0] beat_data;
    channel_t          beat_channel;
    logic              beat_last;

    modport src (
        output beat_valid,
        output beat_data,
        output beat_channel,
        output beat_last
    );

    modport snk (
        input beat_valid,
        input beat_data,
        input beat_channel,
        input beat_last
    );

endinterface

`default_nettype wire

// File: common/isp_pkg.sv
`default_nettype none

package isp_pkg;

    // ----------------------------------------------------------------------
    // data widths
    // ----------------------------------------------------------------------
    localparam int pixel_w = 8;
    localparam int beat_w = 128;
    localparam int lanes = beat_w / pixel_w;
    localparam int sum_w = 18;
    localparam int avg_shift = 10;

    // ----------------------------------------------------------------------
    // dram layout
    // ----------------------------------------------------------------------
    localparam int pic_count = 16;
    localparam int pic_no_w = 4;
    localparam int beats_per_pic = 192;
    localparam int beats_per_channel = 64;
    localparam int beat_cnt_w = 8;
    localparam int axi_addr_w = 32;
    localparam int axi_len_w = 8;
    localparam logic [axi_addr_w-1:0] pic_base_addr = 32'h10000;
    localparam logic [axi_addr_w-1:0] pic_stride = 32'd3072;

    // per-picture division count
    localparam int div_w = 5;
    localparam int div_max = 8;

    // scaler opcode
    typedef enum logic [1:0] {
        ratio_quarter,
        ratio_half,
        ratio_keep,
        ratio_double
    } ratio_t;

    typedef enum logic [2:0] {
        st_idle,
        st_check,
        st_addr,
        st_stream,
        st_resp,
        st_done
    } ctrl_state_t;

    typedef enum logic [1:0] {
        ch_red,
        ch_green,
        ch_blue
    } channel_t;

endpackage

`default_nettype wire

// File: exposure/exposure_average.sv
`timescale 1ns/10ps
`default_nettype none

module exposure_average import isp_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          start,
    input  wire logic          wready,
    beat_if.snk                scaled_beat,
    output logic [pixel_w-1:0] avg,
    output logic               sum_done
);

    logic               take;
    logic [1:0]         wt_shift;
    logic [pixel_w-1:0] weighted [lanes];
    logic [pixel_w+1:0] s1 [lanes/4];
    logic [pixel_w+2:0] s2 [2];
    logic [pixel_w+3:0] s3;
    logic [2:0]         v_pipe;
    logic [2:0]         l_pipe;
    logic [sum_w-1:0]   sum;

    // a beat counts only when it is written
    assign take = scaled_beat.beat_valid && wready;

    // green weighs twice red and blue
    assign wt_shift = (scaled_beat.beat_channel == ch_green) ? 2'd1 : 2'd2;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            weighted[i] = scaled_beat.beat_data[i*pixel_w +: pixel_w] >> wt_shift;
        end
    end

    // ----------------------------------------------------------------------
    // adder tree, 16 -> 4 -> 2 -> 1
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int g = 0; g < lanes / 4; g++) begin
            s1[g] <= weighted[4*g] + weighted[4*g+1] + weighted[4*g+2] + weighted[4*g+3];
        end
        s2[0] <= s1[0] + s1[1];
        s2[1] <= s1[2] + s1[3];
        s3 <= s2[0] + s2[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_pipe   <= '0;
            l_pipe   <= '0;
            sum      <= '0;
            sum_done <= 1'b0;
        end else begin
            v_pipe <= {v_pipe[1:0], take};
            l_pipe <= {l_pipe[1:0], take && scaled_beat.beat_last};
            if (start) begin
                sum      <= '0;
                sum_done <= 1'b0;
            end else if (v_pipe[2]) begin
                sum <= sum + s3;
                // last beat has left the tree
                if (l_pipe[2]) sum_done <= 1'b1;
            end
        end
    end

    assign avg = sum[sum_w-1:avg_shift];

endmodule

`default_nettype wire

// File: exposure/exposure_scaler.sv
`timescale 1ns/10ps
`default_nettype none

module exposure_scaler import isp_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire ratio_t ratio,
    input  wire logic   wready,
    beat_if.snk         read_beat,
    beat_if.src         scaled_beat
);

    logic [beat_w-1:0] scaled;
    logic              hold_valid;
    logic [beat_w-1:0] hold_data;
    channel_t          hold_channel;
    logic              hold_last;

    function automatic logic [pixel_w-1:0] scale_px(input logic [pixel_w-1:0] px,
                                                     input ratio_t r);
        case (r)
            ratio_quarter: return px >> 2;
            ratio_half:    return px >> 1;
            // saturate at 255
            ratio_double:  return px[pixel_w-1] ? '1 : {px[pixel_w-2:0], 1'b0};
            default:       return px;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            scaled[i*pixel_w +: pixel_w] = scale_px(read_beat.beat_data[i*pixel_w +: pixel_w], ratio);
        end
    end

    // slot stays full until the write channel takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (read_beat.beat_valid) begin
            hold_valid <= 1'b1;
        end else if (wready) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (read_beat.beat_valid) begin
            hold_data    <= scaled;
            hold_channel <= read_beat.beat_channel;
            hold_last    <= read_beat.beat_last;
        end
    end

    assign scaled_beat.beat_valid = hold_valid;
    assign scaled_beat.beat_data = hold_data;
    assign scaled_beat.beat_channel = hold_channel;
    assign scaled_beat.beat_last = hold_last;

endmodule

`default_nettype wire

// File: isp_top.f
common/isp_pkg.sv
common/beat_if.sv
exposure/exposure_scaler.sv
exposure/exposure_average.sv
verilog/pic_status_table.sv
verilog/isp_ctrl.sv
verilog/isp_top.sv
tests/dram_model.sv
tests/tb_isp.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the isp testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_isp \
    -f isp_top.f -o tb_isp > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_isp > sim.log 2>&1
sim_status=$?

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0

// File: tests/dram_model.sv
`timescale 1ns/10ps
`default_nettype none

// axi slave memory over the picture area, with stall control
module dram_model import isp_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // stall bits: arready, awready, wready, rvalid gap
    input  wire logic [3:0]            stall,
    input  wire logic [axi_addr_w-1:0] araddr,
    input  wire logic [axi_len_w-1:0]  arlen,
    input  wire logic                  arvalid,
    output logic                       arready,
    output logic [beat_w-1:0]          rdata,
    output logic                       rlast,
    output logic                       rvalid,
    input  wire logic                  rready,
    input  wire logic [axi_addr_w-1:0] awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire logic [beat_w-1:0]     wdata,
    input  wire logic                  wlast,
    input  wire logic                  wvalid,
    output logic                       wready,
    output logic                       bvalid,
    input  wire logic                  bready
);

    localparam int mem_beats = pic_count * beats_per_pic;
    localparam int idx_w = 12;

    logic [beat_w-1:0]    mem [mem_beats];
    logic [idx_w-1:0]     r_idx;
    logic [idx_w-1:0]     w_idx;
    logic [axi_len_w-1:0] r_left;
    logic                 r_act;
    logic                 r_shown;
    logic                 b_pend;

    function automatic logic [idx_w-1:0] to_index(input logic [axi_addr_w-1:0] addr);
        return idx_w'((addr - pic_base_addr) >> $clog2(beat_w / 8));
    endfunction

    assign arready = !stall[3];
    assign awready = !stall[2];
    assign wready = !stall[1];
    // a beat once shown stays valid until taken
    assign rvalid = r_act && (r_shown || !stall[0]);
    assign rdata = mem[r_idx];
    assign rlast = (r_left == '0);
    assign bvalid = b_pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_act   <= 1'b0;
            r_shown <= 1'b0;
            r_idx   <= '0;
            r_left  <= '0;
            w_idx   <= '0;
            b_pend  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                r_act  <= 1'b1;
                r_idx  <= to_index(araddr);
                r_left <= arlen;
            end else if (rvalid && rready) begin
                r_idx  <= r_idx + 1'b1;
                r_left <= r_left - 1'b1;
                r_act  <= !rlast;
            end
            r_shown <= rvalid && !rready;
            if (awvalid && awready) begin
                w_idx <= to_index(awaddr);
            end else if (wvalid && wready) begin
                w_idx <= w_idx + 1'b1;
            end
            if (wvalid && wready && wlast) begin
                b_pend <= 1'b1;
            end else if (bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (wvalid && wready) begin
            mem[w_idx] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_isp.sv
`timescale 1ns/10ps
`default_nettype none

module tb_isp import isp_pkg::*; ();

    localparam logic [31:0] lfsr_seed = 32'h888f8ee2;
    localparam logic [31:0] lfsr_taps = 32'h80200003;
    localparam int num_directed = 10;
    localparam int num_requests = 20;
    localparam int max_req_cycles = 1000;
    localparam int max_cycles = 2 * num_requests * max_req_cycles;
    localparam int mem_beats = pic_count * beats_per_pic;

    logic                  clk;
    logic                  rst_n = 1'b0;
    logic                  in_valid = 1'b0;
    logic [pic_no_w-1:0]   in_pic_no = '0;
    logic [1:0]            in_ratio_mode = '0;
    logic                  out_valid;
    logic [pixel_w-1:0]    out_data;
    logic [axi_addr_w-1:0] araddr;
    logic [axi_addr_w-1:0] awaddr;
    logic [axi_len_w-1:0]  arlen;
    logic [axi_len_w-1:0]  awlen;
    logic                  arvalid, arready, rvalid, rready, rlast;
    logic                  awvalid, awready, wvalid, wready, wlast;
    logic                  bvalid, bready;
    logic [beat_w-1:0]     rdata;
    logic [beat_w-1:0]     wdata;
    logic [3:0]            stall = '0;
    logic                  stall_en = 1'b0;
    logic                  dark_req = 1'b0;
    logic [31:0]           lfsr_state = lfsr_seed;
    logic [31:0]           stall_lfsr = lfsr_seed;
    logic [beat_w-1:0]     ref_mem [mem_beats];
    int                    ref_div [pic_count];
    logic [pixel_w-1:0]    exp_q [$];
    logic                  dark_q [$];
    int                    issue_q [$];
    int                    cycle = 0;
    int                    sent = 0;
    int                    seen = 0;
    int                    error_count = 0;

    isp_top dut (.*);

    dram_model u_dram (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // random source and reference
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return val;
    endfunction

    // expected answer, updates the reference picture and count
    function automatic logic [pixel_w-1:0] ref_request(input int pic, input int ratio);
        int sum;
        int px;
        int base;
        int nxt;
        if (ref_div[pic] == 0) begin
            return '0;
        end
        sum = 0;
        base = pic * beats_per_pic;
        for (int b = 0; b < beats_per_pic; b++) begin
            for (int l = 0; l < lanes; l++) begin
                px = int'(ref_mem[base + b][l*pixel_w +: pixel_w]);
                case (ratio)
                    0: px = px / 4;
                    1: px = px / 2;
                    3: px = (px * 2 > 255) ? 255 : px * 2;
                    default: px = px;
                endcase
                ref_mem[base + b][l*pixel_w +: pixel_w] = pixel_w'(px);
                // green at half weight, red and blue at a quarter
                sum += (b / beats_per_channel == 1) ? px / 2 : px / 4;
            end
        end
        nxt = ref_div[pic] - 2 + ratio;
        ref_div[pic] = (nxt < 0) ? 0 : ((nxt > div_max) ? div_max : nxt);
        return pixel_w'(sum >> avg_shift);
    endfunction

    // ----------------------------------------------------------------------
    // error handling
    // ----------------------------------------------------------------------
    task automatic stop_on_error();
        error_count++;
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_value(input string name, input logic [beat_w-1:0] got,
                              input logic [beat_w-1:0] expected);
        $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, expected);
        stop_on_error();
    endtask

    task automatic fail_text(input string msg);
        $display("%s at time %0t", msg, $time);
        stop_on_error();
    endtask

    // ----------------------------------------------------------------------
    // stimulus tasks
    // ----------------------------------------------------------------------
    task automatic fill_memory();
        for (int i = 0; i < mem_beats; i++) begin
            for (int k = 0; k < beat_w / 32; k++) begin
                ref_mem[i][k*32 +: 32] = draw_bits(32);
            end
            u_dram.mem[i] <= ref_mem[i];
        end
    endtask

    task automatic issue_request(input int pic, input int ratio);
        logic [pixel_w-1:0] expected;
        logic               is_dark;
        is_dark = (ref_div[pic] == 0);
        expected = ref_request(pic, ratio);
        @(posedge clk);
        exp_q.push_back(expected);
        dark_q.push_back(is_dark);
        issue_q.push_back(cycle);
        dark_req = is_dark;
        in_valid <= 1'b1;
        in_pic_no <= pic_no_w'(pic);
        in_ratio_mode <= 2'(ratio);
        sent++;
        @(posedge clk);
        in_valid <= 1'b0;
        while (seen < sent) begin
            @(posedge clk);
        end
        dark_req = 1'b0;
    endtask

    task automatic check_picture(input int pic);
        int idx;
        for (int b = 0; b < beats_per_pic; b++) begin
            idx = pic * beats_per_pic + b;
            assert (u_dram.mem[idx] == ref_mem[idx])
                else fail_value($sformatf("u_dram.mem[%0d]", idx), u_dram.mem[idx], ref_mem[idx]);
        end
    endtask

    // ----------------------------------------------------------------------
    // stalls, timeout and answer check
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (stall_en) begin
            for (int i = 0; i < 4; i++) begin
                // stall roughly one cycle in four
                stall[i] <= stall_lfsr[0] & stall_lfsr[1];
                stall_lfsr = lfsr_step(lfsr_step(stall_lfsr));
            end
        end else begin
            stall <= '0;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        assert (cycle < max_cycles)
            else fail_text("timeout, the DUT did not finish within the cycle limit");
    end

    always @(posedge clk) begin
        assert (!(dark_req && arvalid))
            else fail_text("read burst issued for a dark picture");
        // write burst covers the whole picture
        if (awvalid) begin
            assert (awlen == axi_len_w'(beats_per_pic - 1))
                else fail_value("awlen", beat_w'(awlen), beat_w'(beats_per_pic - 1));
        end
        if (out_valid) begin
            assert (exp_q.size() > 0)
                else fail_text("out_valid with no request pending");
            assert (out_data == exp_q[0])
                else fail_value("out_data", beat_w'(out_data), beat_w'(exp_q[0]));
            if (dark_q[0]) begin
                // drive edge, two cycles, then the sampling edge
                assert (cycle == issue_q[0] + 3)
                    else fail_text("dark answer not two cycles after in_valid");
            end
            exp_q.delete(0);
            dark_q.delete(0);
            issue_q.delete(0);
            seen <= seen + 1;
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [31:0] rnd;
        for (int p = 0; p < pic_count; p++) begin
            ref_div[p] = div_max;
        end
        fill_memory();
        stall_lfsr = lfsr_state;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        issue_request(0, ratio_keep);
        check_picture(0);
        // halving twice compounds in memory
        issue_request(1, ratio_half);
        issue_request(1, ratio_half);
        check_picture(1);
        issue_request(2, ratio_quarter);
        check_picture(2);
        issue_request(3, ratio_double);
        check_picture(3);
        // four quarters use up all divisions
        repeat (4) issue_request(4, ratio_quarter);
        issue_request(4, ratio_double);
        check_picture(4);

        stall_en <= 1'b1;
        for (int n = 0; n < num_requests - num_directed; n++) begin
            rnd = draw_bits(6);
            issue_request(int'(rnd[5:2]), int'(rnd[1:0]));
        end

        // quiet tail, a stray answer here has no request to match
        repeat (20) @(posedge clk);
        for (int p = 0; p < pic_count; p++) begin
            check_picture(p);
        end
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/isp_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module isp_ctrl import isp_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  in_valid,
    input  wire logic [pic_no_w-1:0]   in_pic_no,
    input  wire logic [1:0]            in_ratio_mode,
    input  wire logic                  dark,
    input  wire logic                  sum_done,
    input  wire logic [pixel_w-1:0]    avg,
    input  wire logic                  arready,
    input  wire logic                  rvalid,
    input  wire logic [beat_w-1:0]     rdata,
    input  wire logic                  rlast,
    input  wire logic                  awready,
    input  wire logic                  wready,
    input  wire logic                  bvalid,
    output logic                       out_valid,
    output logic [pixel_w-1:0]         out_data,
    output logic [axi_addr_w-1:0]      araddr,
    output logic [axi_len_w-1:0]       arlen,
    output logic                       arvalid,
    output logic                       rready,
    output logic [axi_addr_w-1:0]      awaddr,
    output logic [axi_len_w-1:0]       awlen,
    output logic                       awvalid,
    output logic                       wvalid,
    output logic                       wlast,
    output logic                       bready,
    output logic [pic_no_w-1:0]        pic_no,
    output ratio_t                     ratio,
    output logic                       update,
    output logic                       start,
    beat_if.src                        read_beat,
    beat_if.snk                        scaled_beat
);

    ctrl_state_t           state;
    ctrl_state_t           state_nxt;
    logic [beat_cnt_w-1:0] rd_cnt;
    logic                  ar_pend;
    logic                  aw_pend;
    logic                  addr_done;
    logic                  rd_fire;
    logic                  w_fire;

    assign rd_fire = rvalid && rready;
    assign w_fire = scaled_beat.beat_valid && wready;
    assign addr_done = (!ar_pend || arready) && (!aw_pend || awready);

    // ----------------------------------------------------------------------
    // request fsm
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:   if (in_valid) state_nxt = st_check;
            st_check:  state_nxt = dark ? st_idle : st_addr;
            st_addr:   if (addr_done) state_nxt = st_stream;
            st_stream: if (w_fire && scaled_beat.beat_last) state_nxt = st_resp;
            st_resp:   if (bvalid) state_nxt = st_done;
            st_done:   if (sum_done) state_nxt = st_idle;
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            pic_no <= '0;
            ratio  <= ratio_keep;
        end else begin
            state <= state_nxt;
            if (state == st_idle && in_valid) begin
                pic_no <= in_pic_no;
                ratio  <= ratio_t'(in_ratio_mode);
            end
        end
    end

    // table write-back and average clear, once per served request
    assign update = (state == st_check) && !dark;
    assign start = update;

    // ----------------------------------------------------------------------
    // axi address channels
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_pend <= 1'b0;
            aw_pend <= 1'b0;
        end else if (update) begin
            ar_pend <= 1'b1;
            aw_pend <= 1'b1;
        end else begin
            if (arready) ar_pend <= 1'b0;
            if (awready) aw_pend <= 1'b0;
        end
    end

    // same address for read and write back
    assign araddr = pic_base_addr + pic_stride * pic_no;
    assign awaddr = araddr;
    assign arlen = axi_len_w'(beats_per_pic - 1);
    assign awlen = arlen;
    assign arvalid = ar_pend;
    assign awvalid = aw_pend;

    // ----------------------------------------------------------------------
    // data channels
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
        end else if (state == st_check) begin
            rd_cnt <= '0;
        end else if (rd_fire) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // only read while the scaler slot is free or draining
    assign rready = (state == st_stream) && (rd_cnt != beat_cnt_w'(beats_per_pic))
                    && (!scaled_beat.beat_valid || wready);

    assign read_beat.beat_valid = rd_fire;
    assign read_beat.beat_data = rdata;
    assign read_beat.beat_channel = channel_t'(2'(rd_cnt / beats_per_channel));
    assign read_beat.beat_last = rlast;

    assign wvalid = scaled_beat.beat_valid;
    assign wlast = scaled_beat.beat_valid && scaled_beat.beat_last;
    assign bready = (state == st_resp);

    // answer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= (state == st_check && dark) || (state == st_done && sum_done);
            out_data  <= (state == st_done) ? avg : '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/isp_top.sv
`timescale 1ns/10ps
`default_nettype none

module isp_top import isp_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // request and answer
    input  wire logic                  in_valid,
    input  wire logic [pic_no_w-1:0]   in_pic_no,
    input  wire logic [1:0]            in_ratio_mode,
    output logic                       out_valid,
    output logic [pixel_w-1:0]         out_data,
    // axi read
    output logic [axi_addr_w-1:0]      araddr,
    output logic [axi_len_w-1:0]       arlen,
    output logic                       arvalid,
    input  wire logic                  arready,
    input  wire logic [beat_w-1:0]     rdata,
    input  wire logic                  rlast,
    input  wire logic                  rvalid,
    output logic                       rready,
    // axi write
    output logic [axi_addr_w-1:0]      awaddr,
    output logic [axi_len_w-1:0]       awlen,
    output logic                       awvalid,
    input  wire logic                  awready,
    output logic [beat_w-1:0]          wdata,
    output logic                       wlast,
    output logic                       wvalid,
    input  wire logic                  wready,
    input  wire logic                  bvalid,
    output logic                       bready
);

    logic [pic_no_w-1:0] pic_no;
    ratio_t              ratio;
    logic                update;
    logic                start;
    logic                dark;
    logic                sum_done;
    logic [pixel_w-1:0]  avg;

    beat_if read_beat ();
    beat_if scaled_beat ();

    isp_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_pic_no(in_pic_no), .in_ratio_mode(in_ratio_mode),
        .dark(dark), .sum_done(sum_done), .avg(avg),
        .arready(arready), .rvalid(rvalid), .rdata(rdata), .rlast(rlast),
        .awready(awready), .wready(wready), .bvalid(bvalid),
        .out_valid(out_valid), .out_data(out_data),
        .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .rready(rready),
        .awaddr(awaddr), .awlen(awlen), .awvalid(awvalid),
        .wvalid(wvalid), .wlast(wlast), .bready(bready),
        .pic_no(pic_no), .ratio(ratio), .update(update), .start(start),
        .read_beat(read_beat.src), .scaled_beat(scaled_beat.snk)
    );

    pic_status_table u_table (
        .clk(clk), .rst_n(rst_n),
        .pic_no(pic_no), .ratio(ratio), .update(update),
        .dark(dark)
    );

    exposure_scaler u_scaler (
        .clk(clk), .rst_n(rst_n),
        .ratio(ratio), .wready(wready),
        .read_beat(read_beat.snk), .scaled_beat(scaled_beat.src)
    );

    exposure_average u_average (
        .clk(clk), .rst_n(rst_n),
        .start(start), .wready(wready),
        .scaled_beat(scaled_beat.snk),
        .avg(avg), .sum_done(sum_done)
    );

    // scaled beat goes straight out as write data
    assign wdata = scaled_beat.beat_data;

endmodule

`default_nettype wire

// File: verilog/pic_status_table.sv
`timescale 1ns/10ps
`default_nettype none

module pic_status_table import isp_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [pic_no_w-1:0] pic_no,
    input  wire ratio_t              ratio,
    input  wire logic                update,
    output logic                     dark
);

    logic signed [div_w-1:0] div_cnt [pic_count];
    logic signed [div_w-1:0] cur_cnt;
    logic signed [div_w-1:0] raw_cnt;
    logic signed [div_w-1:0] new_cnt;

    assign cur_cnt = div_cnt[pic_no];

    // all divisions used up, picture is black
    assign dark = (cur_cnt == '0);

    // old count minus two plus ratio
    assign raw_cnt = cur_cnt - div_w'(2) + $signed(div_w'(ratio));

    always_comb begin
        if (raw_cnt < 0) begin
            new_cnt = '0;
        end else if (raw_cnt > div_max) begin
            new_cnt = div_w'(div_max);
        end else begin
            new_cnt = raw_cnt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pic_count; i++) begin
                div_cnt[i] <= div_w'(div_max);
            end
        end else if (update) begin
            div_cnt[pic_no] <= new_cnt;
        end
    end

endmodule

`default_nettype wire
